// File: radio_fe_cfg.svh
`ifndef RADIO_FE_CFG_SVH
`define RADIO_FE_CFG_SVH

// channel count and datapath widths
`define RADIO_FE_NUM_CHAN 2
`define SAMPLE_W          32
`define IQ_W              16
`define PPS_CNT_W         8

// wishbone, bit 8 of the address picks the channel
`define WB_ADR_W          9
`define WB_DAT_W          32

//////////////////////////////////////////////////
// register map, low 8 address bits
//////////////////////////////////////////////////
`define SR_MISC_OUT       8'd0
`define SR_MISC_IN        8'd1
`define SR_PPS_COUNT      8'd2   // same for both channels

`define SR_TX_FE_BASE     8'd224
`define SR_TX_OFFSET_I    (`SR_TX_FE_BASE + 8'd0)
`define SR_TX_OFFSET_Q    (`SR_TX_FE_BASE + 8'd1)
`define SR_TX_MUX         (`SR_TX_FE_BASE + 8'd4)   // bit 0 swap

`define SR_RX_FE_BASE     8'd232
`define SR_RX_OFFSET_I    (`SR_RX_FE_BASE + 8'd2)
`define SR_RX_OFFSET_Q    (`SR_RX_FE_BASE + 8'd3)
`define SR_RX_IQ_MAP      (`SR_RX_FE_BASE + 8'd4)   // bit 0 swap, bit 1 negate q

`endif

// File: radio_fe_pkg.sv
`default_nettype none

`include "radio_fe_cfg.svh"

package radio_fe_pkg;

   // one signed I or Q component
   typedef logic signed [`IQ_W-1:0] iq_t;

   // converter word, moved whole at the ports and split for correction
   typedef union packed {
      logic [`SAMPLE_W-1:0] raw;
      struct packed {
         iq_t i;   // upper half
         iq_t q;   // lower half
      } iq;
   } sample_t;

   // clamp a one-bit-wider sum back into iq_t range
   function automatic iq_t sat_iq(input logic signed [`IQ_W:0] sum);
      if (sum[`IQ_W] != sum[`IQ_W-1]) begin
         // overflow, sign bit tells which rail
         return sum[`IQ_W] ? {1'b1, {(`IQ_W-1){1'b0}}} : {1'b0, {(`IQ_W-1){1'b1}}};
      end
      return sum[`IQ_W-1:0];
   endfunction

endpackage

`default_nettype wire

// File: fe_settings_wb.sv
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_cfg.svh"

module fe_settings_wb
   import radio_fe_pkg::*;
(
   input  logic                         radio_clk,
   input  logic                         i_reset,
   // wishbone classic slave
   input  logic                         i_wb_cyc,
   input  logic                         i_wb_stb,
   input  logic                         i_wb_we,
   input  logic [`WB_ADR_W-1:0]         i_wb_adr,
   input  logic [`WB_DAT_W-1:0]         i_wb_dat,
   output logic                         o_wb_ack,
   output logic [`WB_DAT_W-1:0]         o_wb_dat,
   // status in
   input  logic [`PPS_CNT_W-1:0]        i_pps_count,
   input  logic [`WB_DAT_W-1:0]         i_misc_in [`RADIO_FE_NUM_CHAN],
   // correction fields per channel
   output iq_t                          o_tx_offset_i [`RADIO_FE_NUM_CHAN],
   output iq_t                          o_tx_offset_q [`RADIO_FE_NUM_CHAN],
   output logic [`RADIO_FE_NUM_CHAN-1:0] o_tx_swap,
   output iq_t                          o_rx_offset_i [`RADIO_FE_NUM_CHAN],
   output iq_t                          o_rx_offset_q [`RADIO_FE_NUM_CHAN],
   output logic [`RADIO_FE_NUM_CHAN-1:0] o_rx_swap,
   output logic [`RADIO_FE_NUM_CHAN-1:0] o_rx_negate_q,
   output logic [`WB_DAT_W-1:0]         o_misc_out [`RADIO_FE_NUM_CHAN]
);

   logic                  wb_req;
   logic                  wb_wr;
   logic                  chan;
   logic [`WB_ADR_W-2:0]  reg_addr;
   logic [`WB_DAT_W-1:0]  misc_in_r [`RADIO_FE_NUM_CHAN];
   logic [`WB_DAT_W-1:0]  rd_data;

   assign wb_req   = i_wb_cyc & i_wb_stb & ~o_wb_ack;   // one ack per request
   assign wb_wr    = wb_req & i_wb_we;
   assign chan     = i_wb_adr[`WB_ADR_W-1];
   assign reg_addr = i_wb_adr[`WB_ADR_W-2:0];

   //////////////////////////////////////////////////
   // register writes
   //////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         for (int ch = 0; ch < `RADIO_FE_NUM_CHAN; ch++) begin
            o_tx_offset_i[ch] <= '0;
            o_tx_offset_q[ch] <= '0;
            o_rx_offset_i[ch] <= '0;
            o_rx_offset_q[ch] <= '0;
            o_misc_out[ch]    <= '0;
         end
         o_tx_swap     <= '0;
         o_rx_swap     <= '0;
         o_rx_negate_q <= '0;
      end else if (wb_wr) begin
         case (reg_addr)
            `SR_MISC_OUT:    o_misc_out[chan]    <= i_wb_dat;
            `SR_TX_OFFSET_I: o_tx_offset_i[chan] <= i_wb_dat[`IQ_W-1:0];
            `SR_TX_OFFSET_Q: o_tx_offset_q[chan] <= i_wb_dat[`IQ_W-1:0];
            `SR_TX_MUX:      o_tx_swap[chan]     <= i_wb_dat[0];
            `SR_RX_OFFSET_I: o_rx_offset_i[chan] <= i_wb_dat[`IQ_W-1:0];
            `SR_RX_OFFSET_Q: o_rx_offset_q[chan] <= i_wb_dat[`IQ_W-1:0];
            `SR_RX_IQ_MAP: begin
               o_rx_swap[chan]     <= i_wb_dat[0];
               o_rx_negate_q[chan] <= i_wb_dat[1];
            end
            default: ;   // read-only or unmapped
         endcase
      end
   end

   always_ff @(posedge radio_clk) begin
      misc_in_r <= i_misc_in;
   end

   //////////////////////////////////////////////////
   // readback and ack
   //////////////////////////////////////////////////
   always_comb begin
      rd_data = '0;   // unmapped reads zero
      case (reg_addr)
         `SR_MISC_OUT:    rd_data = o_misc_out[chan];
         `SR_MISC_IN:     rd_data = misc_in_r[chan];
         `SR_PPS_COUNT:   rd_data[`PPS_CNT_W-1:0] = i_pps_count;
         `SR_TX_OFFSET_I: rd_data[`IQ_W-1:0] = o_tx_offset_i[chan];
         `SR_TX_OFFSET_Q: rd_data[`IQ_W-1:0] = o_tx_offset_q[chan];
         `SR_TX_MUX:      rd_data[0] = o_tx_swap[chan];
         `SR_RX_OFFSET_I: rd_data[`IQ_W-1:0] = o_rx_offset_i[chan];
         `SR_RX_OFFSET_Q: rd_data[`IQ_W-1:0] = o_rx_offset_q[chan];
         `SR_RX_IQ_MAP:   rd_data[1:0] = {o_rx_negate_q[chan], o_rx_swap[chan]};
         default: ;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) o_wb_ack <= 1'b0;
      else         o_wb_ack <= wb_req;
   end

   always_ff @(posedge radio_clk) begin
      if (wb_req) o_wb_dat <= rd_data;   // held through the ack cycle
   end

endmodule

`default_nettype wire

// File: pps_edge_sync.sv
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_cfg.svh"

module pps_edge_sync (
   input  logic                  radio_clk,
   input  logic                  i_reset,
   input  logic                  i_pps,
   output logic [`PPS_CNT_W-1:0] o_pps_count
);

   logic pps_meta;   // first synchronizer flop
   logic pps_sync;
   logic pps_prev;
   logic pps_edge;

   // i_pps is asynchronous to radio_clk
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         pps_meta    <= 1'b0;
         pps_sync    <= 1'b0;
         pps_prev    <= 1'b0;
         pps_edge    <= 1'b0;
         o_pps_count <= '0;
      end else begin
         pps_meta <= i_pps;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;
         pps_edge <= pps_sync & ~pps_prev;   // registered rising edge
         if (pps_edge) begin
            o_pps_count <= o_pps_count + 1'b1;   // wraps at 8 bits
         end
      end
   end

endmodule

`default_nettype wire

// File: tx_fe_corr.sv
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_cfg.svh"

module tx_fe_corr
   import radio_fe_pkg::*;
(
   input  logic    radio_clk,
   input  logic    i_reset,
   input  sample_t i_sample,
   input  iq_t     i_offset_i,
   input  iq_t     i_offset_q,
   input  logic    i_swap,
   output sample_t o_sample
);

   logic signed [`IQ_W:0] sum_i;
   logic signed [`IQ_W:0] sum_q;
   sample_t               corr_r;   // stage one result
   logic                  swap_r;

   //////////////////////////////////////////////////
   // stage one, dc offset
   //////////////////////////////////////////////////

   // one extra bit so the sum cannot wrap
   always_comb begin
      sum_i = i_sample.iq.i + i_offset_i;
      sum_q = i_sample.iq.q + i_offset_q;
   end

   always_ff @(posedge radio_clk) begin
      corr_r.iq.i <= sat_iq(sum_i);
      corr_r.iq.q <= sat_iq(sum_q);
   end

   // swap travels with its sample
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         swap_r <= 1'b0;
      end else begin
         swap_r <= i_swap;
      end
   end

   //////////////////////////////////////////////////
   // stage two, i/q swap
   //////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (swap_r) begin
         o_sample.raw <= {corr_r.iq.q, corr_r.iq.i};   // halves exchanged
      end else begin
         o_sample.raw <= corr_r.raw;
      end
   end

endmodule

`default_nettype wire

// File: rx_fe_corr.sv
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_cfg.svh"

module rx_fe_corr
   import radio_fe_pkg::*;
(
   input  logic    radio_clk,
   input  logic    i_reset,
   input  sample_t i_sample,
   input  iq_t     i_offset_i,
   input  iq_t     i_offset_q,
   input  logic    i_swap,
   input  logic    i_negate_q,
   output sample_t o_sample
);

   logic signed [`IQ_W:0] diff_i;
   logic signed [`IQ_W:0] diff_q;
   sample_t               diff_r;   // stage one result
   logic                  swap_r;
   logic                  negate_r;
   sample_t               swapped;
   logic signed [`IQ_W:0] q_ext;
   logic signed [`IQ_W:0] q_neg;

   //////////////////////////////////////////////////
   // stage one, dc offset removal
   //////////////////////////////////////////////////
   always_comb begin
      diff_i = i_sample.iq.i - i_offset_i;
      diff_q = i_sample.iq.q - i_offset_q;
   end

   always_ff @(posedge radio_clk) begin
      diff_r.iq.i <= sat_iq(diff_i);
      diff_r.iq.q <= sat_iq(diff_q);
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         swap_r   <= 1'b0;
         negate_r <= 1'b0;
      end else begin
         swap_r   <= i_swap;     // mapping taken with the sample
         negate_r <= i_negate_q;
      end
   end

   //////////////////////////////////////////////////
   // stage two, swap then negate q
   //////////////////////////////////////////////////
   always_comb begin
      swapped.raw = swap_r ? {diff_r.iq.q, diff_r.iq.i} : diff_r.raw;
      q_ext       = swapped.iq.q;   // sign extend before negate
      q_neg       = -q_ext;
   end

   // -32768 negated clamps to 32767
   always_ff @(posedge radio_clk) begin
      o_sample.iq.i <= swapped.iq.i;
      o_sample.iq.q <= negate_r ? sat_iq(q_neg) : swapped.iq.q;
   end

endmodule

`default_nettype wire

// File: radio_fe_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_cfg.svh"

module radio_fe_top
   import radio_fe_pkg::*;
(
   input  logic                 radio_clk,
   input  logic                 i_reset,
   // host bus
   input  logic                 i_wb_cyc,
   input  logic                 i_wb_stb,
   input  logic                 i_wb_we,
   input  logic [`WB_ADR_W-1:0] i_wb_adr,
   input  logic [`WB_DAT_W-1:0] i_wb_dat,
   output logic                 o_wb_ack,
   output logic [`WB_DAT_W-1:0] o_wb_dat,
   input  logic                 i_pps,
   // converter streams, one word per clock
   input  logic [`SAMPLE_W-1:0] i_rx0,
   input  logic [`SAMPLE_W-1:0] i_rx1,
   input  logic [`SAMPLE_W-1:0] i_tx0,
   input  logic [`SAMPLE_W-1:0] i_tx1,
   output logic [`SAMPLE_W-1:0] o_rx0,
   output logic [`SAMPLE_W-1:0] o_rx1,
   output logic [`SAMPLE_W-1:0] o_tx0,
   output logic [`SAMPLE_W-1:0] o_tx1,
   // misc words
   input  logic [`WB_DAT_W-1:0] i_misc_in0,
   input  logic [`WB_DAT_W-1:0] i_misc_in1,
   output logic [`WB_DAT_W-1:0] o_misc_out0,
   output logic [`WB_DAT_W-1:0] o_misc_out1
);

   iq_t                          tx_offset_i [`RADIO_FE_NUM_CHAN];
   iq_t                          tx_offset_q [`RADIO_FE_NUM_CHAN];
   iq_t                          rx_offset_i [`RADIO_FE_NUM_CHAN];
   iq_t                          rx_offset_q [`RADIO_FE_NUM_CHAN];
   logic [`RADIO_FE_NUM_CHAN-1:0] tx_swap;
   logic [`RADIO_FE_NUM_CHAN-1:0] rx_swap;
   logic [`RADIO_FE_NUM_CHAN-1:0] rx_negate_q;
   logic [`PPS_CNT_W-1:0]        pps_count;
   logic [`WB_DAT_W-1:0]         misc_in [`RADIO_FE_NUM_CHAN];
   logic [`WB_DAT_W-1:0]         misc_out [`RADIO_FE_NUM_CHAN];

   assign misc_in[0]  = i_misc_in0;
   assign misc_in[1]  = i_misc_in1;
   assign o_misc_out0 = misc_out[0];   // straight from the register
   assign o_misc_out1 = misc_out[1];

   //////////////////////////////////////////////////
   // settings and pps
   //////////////////////////////////////////////////
   fe_settings_wb i_fe_settings_wb (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_wb_cyc      (i_wb_cyc),
      .i_wb_stb      (i_wb_stb),
      .i_wb_we       (i_wb_we),
      .i_wb_adr      (i_wb_adr),
      .i_wb_dat      (i_wb_dat),
      .o_wb_ack      (o_wb_ack),
      .o_wb_dat      (o_wb_dat),
      .i_pps_count   (pps_count),
      .i_misc_in     (misc_in),
      .o_tx_offset_i (tx_offset_i),
      .o_tx_offset_q (tx_offset_q),
      .o_tx_swap     (tx_swap),
      .o_rx_offset_i (rx_offset_i),
      .o_rx_offset_q (rx_offset_q),
      .o_rx_swap     (rx_swap),
      .o_rx_negate_q (rx_negate_q),
      .o_misc_out    (misc_out)
   );

   pps_edge_sync i_pps_edge_sync (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_pps       (i_pps),
      .o_pps_count (pps_count)
   );

   //////////////////////////////////////////////////
   // per channel correction
   //////////////////////////////////////////////////
   tx_fe_corr i_tx_fe_corr0 (
      .radio_clk (radio_clk), .i_reset (i_reset),
      .i_sample  (i_tx0),
      .i_offset_i(tx_offset_i[0]), .i_offset_q(tx_offset_q[0]),
      .i_swap    (tx_swap[0]),
      .o_sample  (o_tx0)
   );

   tx_fe_corr i_tx_fe_corr1 (
      .radio_clk (radio_clk), .i_reset (i_reset),
      .i_sample  (i_tx1),
      .i_offset_i(tx_offset_i[1]), .i_offset_q(tx_offset_q[1]),
      .i_swap    (tx_swap[1]),
      .o_sample  (o_tx1)
   );

   rx_fe_corr i_rx_fe_corr0 (
      .radio_clk (radio_clk), .i_reset (i_reset),
      .i_sample  (i_rx0),
      .i_offset_i(rx_offset_i[0]), .i_offset_q(rx_offset_q[0]),
      .i_swap    (rx_swap[0]), .i_negate_q(rx_negate_q[0]),
      .o_sample  (o_rx0)
   );

   rx_fe_corr i_rx_fe_corr1 (
      .radio_clk (radio_clk), .i_reset (i_reset),
      .i_sample  (i_rx1),
      .i_offset_i(rx_offset_i[1]), .i_offset_q(rx_offset_q[1]),
      .i_swap    (rx_swap[1]), .i_negate_q(rx_negate_q[1]),
      .o_sample  (o_rx1)
   );

endmodule

`default_nettype wire

// File: tb_radio_fe.sv
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_cfg.svh"

module tb_radio_fe;

   localparam logic [1:0] OP_WR  = 2'd0;
   localparam logic [1:0] OP_RD  = 2'd1;
   localparam logic [1:0] OP_RX  = 2'd2;   // one sample through rx correction
   localparam logic [1:0] OP_TX  = 2'd3;
   localparam int         RAND_N = 32;    // random pass-through samples

   typedef struct packed {
      logic [1:0]  op;
      logic        ch;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [3:0]  pps;        // pulses sent before the entry
      logic [31:0] expected;
   } entry_t;

   logic                 radio_clk;
   logic                 reset;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   logic [`WB_ADR_W-1:0] wb_adr;
   logic [31:0]          wb_dat_w;
   logic                 wb_ack;
   logic [31:0]          wb_dat_r;
   logic                 pps;
   logic [31:0]          rx_in [2];
   logic [31:0]          tx_in [2];
   logic [31:0]          rx_out [2];
   logic [31:0]          tx_out [2];
   logic [31:0]          misc_in [2];
   logic [31:0]          misc_out [2];

   entry_t               table_q [$];
   int                   errors;
   int                   cycles;
   int                   cycle_limit;

   radio_fe_top i_radio_fe_top (
      .radio_clk   (radio_clk),
      .i_reset     (reset),
      .i_wb_cyc    (wb_cyc),
      .i_wb_stb    (wb_stb),
      .i_wb_we     (wb_we),
      .i_wb_adr    (wb_adr),
      .i_wb_dat    (wb_dat_w),
      .o_wb_ack    (wb_ack),
      .o_wb_dat    (wb_dat_r),
      .i_pps       (pps),
      .i_rx0       (rx_in[0]),
      .i_rx1       (rx_in[1]),
      .i_tx0       (tx_in[0]),
      .i_tx1       (tx_in[1]),
      .o_rx0       (rx_out[0]),
      .o_rx1       (rx_out[1]),
      .o_tx0       (tx_out[0]),
      .o_tx1       (tx_out[1]),
      .i_misc_in0  (misc_in[0]),
      .i_misc_in1  (misc_in[1]),
      .o_misc_out0 (misc_out[0]),
      .o_misc_out1 (misc_out[1])
   );

   always #50 radio_clk = ~radio_clk;   // 100 ns period

   // run limit
   always @(posedge radio_clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, the table did not complete", cycles);
         $display("Errors: %0d", errors);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic add_entry(input logic [1:0] op, input logic ch, input logic [7:0] addr,
                            input logic [31:0] data, input logic [3:0] pps_n,
                            input logic [31:0] expected);
      table_q.push_back({op, ch, addr, data, pps_n, expected});
   endtask

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   //////////////////////////////////////////////////
   // bus and stream drivers
   //////////////////////////////////////////////////
   task automatic bus_access(input logic we, input logic ch, input logic [7:0] addr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = {ch, addr};
      wb_dat_w = wdat;
      do begin
         @(posedge radio_clk);
         #1;
         waited++;
      end while (!wb_ack && waited < 4);
      assert (wb_ack && waited == 1) else begin
         errors++;
         $display("Error at %0t: no ack on the first edge for address %h", $time, wb_adr);
      end
      rdat   = wb_dat_r;   // held while ack is high
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(posedge radio_clk);
      #1;
      assert (!wb_ack) else begin
         errors++;
         $display("Error at %0t: ack stayed high for more than one cycle", $time);
      end
   endtask

   // one sample in and its result two edges later
   task automatic stream_sample(input logic is_rx, input logic ch, input logic [31:0] din,
                                input logic [31:0] exp);
      if (is_rx) rx_in[ch] = din;
      else       tx_in[ch] = din;
      @(posedge radio_clk);
      #1;
      rx_in[ch] = '0;
      tx_in[ch] = '0;
      @(posedge radio_clk);
      #1;
      check_word($sformatf("%s%0d output", is_rx ? "rx" : "tx", ch),
                 is_rx ? rx_out[ch] : tx_out[ch], exp);
   endtask

   task automatic stream_random();
      logic [31:0] hist [RAND_N][4];
      for (int k = 0; k < RAND_N + 2; k++) begin
         for (int c = 0; c < 2; c++) begin
            if (k >= 2) begin
               check_word("rx pass-through", rx_out[c], hist[k-2][c]);
               check_word("tx pass-through", tx_out[c], hist[k-2][c+2]);
            end
            if (k < RAND_N) begin
               hist[k][c]   = $urandom;
               hist[k][c+2] = $urandom;
               rx_in[c]     = hist[k][c];
               tx_in[c]     = hist[k][c+2];
            end
         end
         @(posedge radio_clk);
         #1;
      end
      rx_in = '{default: '0};
      tx_in = '{default: '0};
   endtask

   task automatic pulse_pps(input int n);
      repeat (n) begin
         pps = 1'b1;
         repeat (4) @(posedge radio_clk);
         #1;
         pps = 1'b0;   // gap
         repeat (4) @(posedge radio_clk);
         #1;
      end
   endtask

   //////////////////////////////////////////////////
   // table and main sequence
   //////////////////////////////////////////////////
   initial begin
      entry_t      e;
      logic [31:0] rdat;
      logic [31:0] pat;
      logic [7:0]  regs [7];
      logic [31:0] masks [7];
      regs  = '{`SR_MISC_OUT, `SR_TX_OFFSET_I, `SR_TX_OFFSET_Q, `SR_TX_MUX,
                `SR_RX_OFFSET_I, `SR_RX_OFFSET_Q, `SR_RX_IQ_MAP};
      masks = '{32'hffff_ffff, 32'hffff, 32'hffff, 32'h1, 32'hffff, 32'hffff, 32'h3};
      radio_clk  = 1'b0;
      reset      = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      pps        = 1'b0;
      rx_in      = '{default: '0};
      tx_in      = '{default: '0};
      misc_in[0] = 32'h1234_5678;
      misc_in[1] = 32'h9abc_def0;
      errors     = 0;
      cycles     = 0;
      void'($urandom(32'h1615));

      // reset state and unmapped addresses
      for (int ch = 0; ch < 2; ch++) begin
         for (int r = 0; r < 7; r++) add_entry(OP_RD, ch[0], regs[r], '0, 0, '0);
      end
      add_entry(OP_RD, 0, `SR_MISC_IN, '0, 0, 32'h1234_5678);
      add_entry(OP_RD, 1, `SR_MISC_IN, '0, 0, 32'h9abc_def0);
      add_entry(OP_RD, 0, `SR_PPS_COUNT, '0, 0, '0);
      add_entry(OP_RD, 0, 8'd3, '0, 0, '0);
      add_entry(OP_RD, 1, 8'd232, '0, 0, '0);
      add_entry(OP_WR, 0, 8'd100, 32'hffff_ffff, 0, '0);
      add_entry(OP_RD, 0, 8'd100, '0, 0, '0);
      // channel 0 is read back only after channel 1 was written
      for (int ch = 0; ch < 2; ch++) begin
         for (int r = 0; r < 7; r++) begin
            pat = {16'ha5c3, ch[0] ? 8'h96 : 8'h69, 4'h0, r[2:0], ch[0]};
            add_entry(OP_WR, ch[0], regs[r], pat, 0, '0);
         end
      end
      for (int ch = 0; ch < 2; ch++) begin
         for (int r = 0; r < 7; r++) begin
            pat = {16'ha5c3, ch[0] ? 8'h96 : 8'h69, 4'h0, r[2:0], ch[0]};
            add_entry(OP_RD, ch[0], regs[r], '0, 0, pat & masks[r]);
         end
      end
      // tx offsets +256 and -256
      add_entry(OP_WR, 0, `SR_TX_OFFSET_I, 32'h0000_0100, 0, '0);
      add_entry(OP_WR, 0, `SR_TX_OFFSET_Q, 32'h0000_ff00, 0, '0);
      add_entry(OP_WR, 0, `SR_TX_MUX, 32'h0, 0, '0);
      add_entry(OP_TX, 0, 8'd0, 32'h1000_0200, 0, 32'h1100_0100);
      add_entry(OP_TX, 0, 8'd0, 32'h7f80_8050, 0, 32'h7fff_8000);   // both rails
      add_entry(OP_WR, 0, `SR_TX_MUX, 32'h1, 0, '0);
      add_entry(OP_TX, 0, 8'd0, 32'h1000_0200, 0, 32'h0100_1100);
      add_entry(OP_WR, 1, `SR_TX_OFFSET_I, 32'h0000_0010, 0, '0);
      add_entry(OP_WR, 1, `SR_TX_OFFSET_Q, 32'h0000_fff0, 0, '0);
      add_entry(OP_WR, 1, `SR_TX_MUX, 32'h0, 0, '0);
      add_entry(OP_TX, 1, 8'd0, 32'h0001_0001, 0, 32'h0011_fff1);
      // rx with the same offsets removed
      add_entry(OP_WR, 0, `SR_RX_OFFSET_I, 32'h0000_0100, 0, '0);
      add_entry(OP_WR, 0, `SR_RX_OFFSET_Q, 32'h0000_ff00, 0, '0);
      add_entry(OP_WR, 0, `SR_RX_IQ_MAP, 32'h0, 0, '0);
      add_entry(OP_RX, 0, 8'd0, 32'h1000_0200, 0, 32'h0f00_0300);
      add_entry(OP_RX, 0, 8'd0, 32'h8050_7f80, 0, 32'h8000_7fff);
      add_entry(OP_WR, 0, `SR_RX_IQ_MAP, 32'h1, 0, '0);
      add_entry(OP_RX, 0, 8'd0, 32'h1000_0200, 0, 32'h0300_0f00);
      add_entry(OP_WR, 0, `SR_RX_IQ_MAP, 32'h2, 0, '0);
      add_entry(OP_RX, 0, 8'd0, 32'h1000_0200, 0, 32'h0f00_fd00);
      add_entry(OP_WR, 0, `SR_RX_IQ_MAP, 32'h3, 0, '0);
      add_entry(OP_RX, 0, 8'd0, 32'h1000_0200, 0, 32'h0300_f100);
      add_entry(OP_RX, 0, 8'd0, 32'h8000_0200, 0, 32'h0300_7fff);   // q of -32768 negated
      add_entry(OP_WR, 1, `SR_RX_OFFSET_I, 32'h0000_0020, 0, '0);
      add_entry(OP_WR, 1, `SR_RX_OFFSET_Q, 32'h0000_0030, 0, '0);
      add_entry(OP_WR, 1, `SR_RX_IQ_MAP, 32'h2, 0, '0);
      add_entry(OP_RX, 1, 8'd0, 32'h0100_0100, 0, 32'h00e0_ff30);
      // mapping words with the negate bit set
      add_entry(OP_RD, 1, `SR_RX_IQ_MAP, '0, 0, 32'h2);
      add_entry(OP_RD, 0, `SR_RX_IQ_MAP, '0, 0, 32'h3);
      // misc out per channel and the shared pps count
      add_entry(OP_WR, 1, `SR_MISC_OUT, 32'h0bad_cafe, 0, '0);
      add_entry(OP_RD, 1, `SR_MISC_OUT, '0, 0, 32'h0bad_cafe);
      add_entry(OP_RD, 0, `SR_MISC_OUT, '0, 0, 32'ha5c3_6900);
      add_entry(OP_RD, 0, `SR_PPS_COUNT, '0, 3, 32'd3);
      add_entry(OP_RD, 1, `SR_PPS_COUNT, '0, 2, 32'd5);
      cycle_limit = table_q.size() * 20 + 100;

      repeat (5) @(posedge radio_clk);
      #1;
      reset = 1'b0;
      check_word("ack after reset", {31'b0, wb_ack}, '0);
      check_word("misc output 0 after reset", misc_out[0], '0);
      check_word("misc output 1 after reset", misc_out[1], '0);
      stream_random();

      foreach (table_q[n]) begin
         e = table_q[n];
         pulse_pps(e.pps);
         case (e.op)
            OP_WR: bus_access(1'b1, e.ch, e.addr, e.data, rdat);
            OP_RD: begin
               bus_access(1'b0, e.ch, e.addr, '0, rdat);
               check_word($sformatf("read of ch%0d reg %0d", e.ch, e.addr), rdat, e.expected);
               if (e.addr == `SR_MISC_OUT) check_word("misc output", misc_out[e.ch], e.expected);
            end
            OP_RX: stream_sample(1'b1, e.ch, e.data, e.expected);
            OP_TX: stream_sample(1'b0, e.ch, e.data, e.expected);
         endcase
      end

      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
radio_fe_pkg.sv
fe_settings_wb.sv
pps_edge_sync.sv
tx_fe_corr.sv
rx_fe_corr.sv
radio_fe_top.sv
tb_radio_fe.sv

// File: run_sim.sh
#!/bin/sh
# build and run the radio frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_radio_fe \
   -f sim.f -o tb_radio_fe > build.log 2>&1 \
   && ./obj_dir/tb_radio_fe > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
